//--- design/fetch_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-phase req/ack sequencer for instruction memory
// drops data of a fetch that was cut by a flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fetch_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic mem_ack,
	input  logic queue_full,
	output logic mem_req,
	output logic fetch_done
);

	typedef enum logic [1:0] {
		st_idle,         // req low, ack low seen
		st_wait_ack,     // req high, data wanted
		st_wait_release, // req low, waiting ack low
		st_discard       // req high, data stale after flush
	} state_e;

	state_e state, state_nxt;

	// a flush empties the queue, so full is stale in that cycle
	logic can_start;
	assign can_start = !mem_ack && (!queue_full || flush);

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (can_start)
					state_nxt = st_wait_ack; // pc updates on this edge too
			end
			st_wait_ack: begin
				if (mem_ack)
					state_nxt = st_wait_release; // accepted or dropped below
				else if (flush)
					state_nxt = st_discard; // keep req up till ack
			end
			st_discard: begin
				if (mem_ack)
					state_nxt = st_wait_release;
			end
			st_wait_release: begin
				if (!mem_ack)
					state_nxt = st_idle;
			end
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= st_idle;
		else
			state <= state_nxt;
	end

	// req follows state only, so it drops on the edge ack is seen
	assign mem_req = (state == st_wait_ack) || (state == st_discard);

	// flush in the ack cycle also kills the word
	assign fetch_done = (state == st_wait_ack) && mem_ack && !flush;

endmodule

//--- design/fetch_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, opcodes and entry structs of the fetch unit
// imported by every fetch and issue block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fetch_pkg;

	localparam int ROB_TAG_W = 3; // 8 rob slots
	localparam int BHT_IDX_W = 4; // 16 history bits

	typedef logic [31:0]          xlen_t;
	typedef logic [4:0]           reg_idx_t;
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;
	typedef logic [BHT_IDX_W-1:0] bht_idx_t;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_LUI    = 7'h37;
	localparam logic [6:0] OPC_AUIPC  = 7'h17;
	localparam logic [6:0] OPC_JAL    = 7'h6f;
	localparam logic [6:0] OPC_JALR   = 7'h67;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_LOAD   = 7'h03;
	localparam logic [6:0] OPC_STORE  = 7'h23;
	localparam logic [6:0] OPC_OP     = 7'h33; // reg-reg alu
	localparam logic [6:0] OPC_OP_IMM = 7'h13; // reg-imm alu

	typedef enum logic [2:0] {
		ic_alu,
		ic_load,
		ic_store,
		ic_branch,
		ic_jal,
		ic_jalr,
		ic_lui_auipc
	} inst_class_e;

	// one queue slot, target/taken filled by prediction
	typedef struct packed {
		xlen_t       pc;
		xlen_t       inst;
		inst_class_e cls;
		reg_idx_t    rd;     // 0 for store and branch
		xlen_t       imm;    // sign extended
		xlen_t       target; // predicted jump pc
		logic        taken;  // prediction bit
	} q_entry_t;

	typedef struct packed {
		q_entry_t entry;
		rob_tag_t tag;
	} issue_entry_t;

endpackage

//--- design/ifu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fetch unit top, memory and issue side ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ifu_top import fetch_pkg::*; #(
	parameter int    QUEUE_DEPTH = 8,
	parameter xlen_t RESET_PC    = '0
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         flush,
	input  xlen_t        flush_pc,
	output logic         mem_req,
	output xlen_t        mem_addr,
	input  logic         mem_ack,
	input  xlen_t        mem_data,
	output bht_idx_t     bht_idx,
	input  logic         bht_taken,
	input  logic         rob_full,
	input  logic         slb_full,
	input  logic         rs_full,
	output logic         issue_valid,
	output logic         issue_to_slb,
	output issue_entry_t issue_entry
);

	logic     fetch_done, queue_full, queue_empty, queue_pop;
	xlen_t    pc;
	q_entry_t decoded, predicted, queue_head;

	assign mem_addr = pc; // held stable while req is up

	fetch_ctrl u_ctrl (.clk, .rst, .flush, .mem_ack, .queue_full,
		.mem_req, .fetch_done);

	inst_decode u_dec (.inst(mem_data), .pc, .entry(decoded), .bht_idx);

	pc_gen #(.RESET_PC(RESET_PC)) u_pc (.clk, .rst, .flush, .flush_pc,
		.fetch_done, .fetched(decoded), .bht_taken, .pc, .predicted);

	inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_q (.clk, .rst, .flush,
		.push(fetch_done), .push_entry(predicted), .pop(queue_pop),
		.head(queue_head), .empty(queue_empty), .full(queue_full));

	issue_router u_iss (.clk, .rst, .flush, .empty(queue_empty),
		.head(queue_head), .rob_full, .slb_full, .rs_full, .pop(queue_pop),
		.issue_valid, .issue_to_slb, .issue_entry);

endmodule

//--- design/inst_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational classify, rd and immediate of a fetched word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module inst_decode import fetch_pkg::*; (
	input  xlen_t    inst,
	input  xlen_t    pc,
	output q_entry_t entry,
	output bht_idx_t bht_idx
);

	logic [6:0] opcode;
	assign opcode = inst[6:0];

	// low word bits, byte offset skipped
	assign bht_idx = inst[BHT_IDX_W+1:2];

	always_comb begin
		entry        = '0;
		entry.pc     = pc;
		entry.inst   = inst;
		entry.rd     = inst[11:7];
		entry.cls    = ic_alu;
		entry.imm    = {{20{inst[31]}}, inst[31:20]}; // I type
		case (opcode)
			OPC_LOAD: entry.cls = ic_load;
			OPC_STORE: begin
				entry.cls = ic_store;
				entry.rd  = '0;
				entry.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			OPC_BRANCH: begin
				entry.cls = ic_branch;
				entry.rd  = '0;
				entry.imm = {{19{inst[31]}}, inst[31], inst[7],
					inst[30:25], inst[11:8], 1'b0};
			end
			OPC_JAL: begin
				entry.cls = ic_jal;
				entry.imm = {{11{inst[31]}}, inst[31], inst[19:12],
					inst[20], inst[30:21], 1'b0};
			end
			OPC_JALR: entry.cls = ic_jalr;
			OPC_LUI, OPC_AUIPC: begin
				entry.cls = ic_lui_auipc;
				entry.imm = {inst[31:12], 12'b0}; // U type
			end
			OPC_OP, OPC_OP_IMM: entry.cls = ic_alu;
			default: entry.cls = ic_alu; // unknown goes to rs
		endcase
	end

endmodule

//--- design/inst_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular fetch queue, push from fetch, pop on issue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module inst_queue import fetch_pkg::*; #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     flush,
	input  logic     push,
	input  q_entry_t push_entry,
	input  logic     pop,
	output q_entry_t head,
	output logic     empty,
	output logic     full
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	q_entry_t mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] head_ptr, tail_ptr;
	logic [PTR_W:0]   count; // one extra bit for full

	logic do_push, do_pop;

	assign empty   = (count == '0);
	assign full    = (count == (PTR_W+1)'(QUEUE_DEPTH));
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign head    = mem[head_ptr];

	// wrap works for any depth
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		ptr_inc = (p == (PTR_W)'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
		end else begin
			if (do_push)
				tail_ptr <= ptr_inc(tail_ptr);
			if (do_pop)
				head_ptr <= ptr_inc(head_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[tail_ptr] <= push_entry; // payload only
	end

endmodule

//--- design/issue_router.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issues queue head to slb or rs, tags it with a rob slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module issue_router import fetch_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         flush,
	input  logic         empty,
	input  q_entry_t     head,
	input  logic         rob_full,
	input  logic         slb_full,
	input  logic         rs_full,
	output logic         pop,
	output logic         issue_valid,
	output logic         issue_to_slb,
	output issue_entry_t issue_entry
);

	rob_tag_t tag_cnt; // next rob slot, local copy of rob tail
	logic     target_full;

	// memory ops go to slb, everything else to rs
	assign issue_to_slb = (head.cls == ic_load) || (head.cls == ic_store);
	assign target_full  = issue_to_slb ? slb_full : rs_full;

	// same cycle as head, no staging reg
	assign issue_valid = !empty && !rob_full && !target_full;
	assign pop         = issue_valid; // head stays on stall

	assign issue_entry.entry = head;
	assign issue_entry.tag   = tag_cnt;

	always_ff @(posedge clk) begin
		if (rst || flush)
			tag_cnt <= '0; // rob restarts empty
		else if (issue_valid)
			tag_cnt <= tag_cnt + 1'b1; // wraps mod 2^ROB_TAG_W
	end

endmodule

//--- design/pc_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch pc register and static/bht next-pc prediction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pc_gen import fetch_pkg::*; #(
	parameter xlen_t RESET_PC = '0
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     flush,
	input  xlen_t    flush_pc,
	input  logic     fetch_done,
	input  q_entry_t fetched,   // decoded word from memory
	input  logic     bht_taken, // same cycle as ack
	output xlen_t    pc,
	output q_entry_t predicted
);

	xlen_t pc_plus4;
	xlen_t pc_next;

	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		predicted        = fetched;
		predicted.target = pc_plus4; // fall through
		predicted.taken  = 1'b0;
		case (fetched.cls)
			ic_jal: begin
				predicted.target = pc + fetched.imm; // always taken
				predicted.taken  = 1'b1;
			end
			ic_branch: begin
				predicted.target = pc + fetched.imm;
				predicted.taken  = bht_taken; // history bit decides
			end
			default: ; // jalr predicted not taken
		endcase
	end

	assign pc_next = predicted.taken ? predicted.target : pc_plus4;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= RESET_PC;
		else if (flush)
			pc <= flush_pc; // redirect wins over a fetch
		else if (fetch_done)
			pc <= pc_next;
	end

endmodule

//--- sources.f
design/fetch_pkg.sv
design/fetch_ctrl.sv
design/pc_gen.sv
design/inst_decode.sv
design/inst_queue.sv
design/issue_router.sv
design/ifu_top.sv
verif/ifu_checker.sv
verif/ifu_tb.sv

//--- verif/ifu_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound onto ifu_top to check handshake, next pc and issue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ifu_checker import fetch_pkg::*; (
	input logic         clk, rst, flush, mem_req, mem_ack, bht_taken,
	input logic         rob_full, slb_full, rs_full, issue_valid, issue_to_slb,
	input xlen_t        flush_pc, mem_addr, mem_data,
	input bht_idx_t     bht_idx,
	input issue_entry_t issue_entry
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		xlen_t pc;
		xlen_t inst;
		xlen_t target;
		logic  taken;
	} exp_t;

	exp_t       sb [16];  // expected issue order
	exp_t       exp_head;
	logic [3:0] wr_ptr, rd_ptr;
	logic [4:0] sb_cnt;
	rob_tag_t   exp_tag;
	xlen_t      exp_addr; // next fetch pc
	logic       stale, accept, is_mem;
	int         fail_cnt = 0;

	// jal always taken, branch by t, rest falls through
	function automatic xlen_t next_pc(xlen_t pc, xlen_t w, logic t);
		xlen_t jimm, bimm;
		jimm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		bimm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		case (w[6:0])
			7'h6f: next_pc = pc + jimm;
			7'h63: next_pc = t ? pc + bimm : pc + 32'd4;
			default: next_pc = pc + 32'd4;
		endcase
	endfunction

	assign accept   = mem_req && mem_ack && !flush && !stale; // word kept
	assign exp_head = sb[rd_ptr];
	assign is_mem   = issue_entry.entry.inst[6:0] inside {7'h03, 7'h23};

	always_ff @(posedge clk) begin
		if (rst)
			stale <= 1'b0;
		else if (mem_req && mem_ack)
			stale <= 1'b0;
		else if (flush && mem_req)
			stale <= 1'b1; // word in flight is from the old path
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			sb[wr_ptr] <= '{pc: mem_addr, inst: mem_data,
				target: next_pc(mem_addr, mem_data, 1'b1),
				taken: (mem_data[6:0] == 7'h6f) || (mem_data[6:0] == 7'h63 && bht_taken)};
			exp_addr <= next_pc(mem_addr, mem_data, bht_taken);
		end
		if (flush)
			exp_addr <= flush_pc; // redirect
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			sb_cnt  <= '0;
			exp_tag <= '0; // tags restart after flush
		end else begin
			wr_ptr  <= wr_ptr + 4'(accept);
			rd_ptr  <= rd_ptr + 4'(issue_valid);
			sb_cnt  <= sb_cnt + 5'(accept) - 5'(issue_valid);
			exp_tag <= exp_tag + rob_tag_t'(issue_valid);
		end
	end

	a_req_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(mem_req) |-> !$past(mem_ack)) else begin
		fail_cnt++;
		$error("mem_req rose at %0t while mem_ack was still high", $time);
	end

	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_ack && !flush |=> mem_req && $stable(mem_addr)) else begin
		fail_cnt++;
		$error("mem_req or mem_addr changed at %0t before mem_ack", $time);
	end

	// history index taken from the word in the ack cycle
	a_bht_idx: assert property (@(posedge clk) disable iff (rst)
		mem_req && mem_ack |-> bht_idx == mem_data[BHT_IDX_W+1:2]) else begin
		fail_cnt++;
		$error("Error at %0t: bht_idx %h, expected %h", $time,
			$sampled(bht_idx), $sampled(mem_data[BHT_IDX_W+1:2]));
	end

	a_next_pc: assert property (@(posedge clk) disable iff (rst)
		accept || flush |=> mem_addr == exp_addr) else begin
		fail_cnt++;
		$error("Error at %0t: mem_addr %h, expected %h", $time,
			$sampled(mem_addr), $sampled(exp_addr));
	end

	// issued in fetch order with its prediction
	a_issue_entry: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> sb_cnt != 0 && issue_entry.entry.pc == exp_head.pc
			&& issue_entry.entry.taken == exp_head.taken
			&& issue_entry.entry.target == exp_head.target) else begin
		fail_cnt++;
		$error("Error at %0t: issue_entry pc/taken/target %h/%b/%h, expected %h/%b/%h",
			$time, $sampled(issue_entry.entry.pc), $sampled(issue_entry.entry.taken),
			$sampled(issue_entry.entry.target), $sampled(exp_head.pc),
			$sampled(exp_head.taken), $sampled(exp_head.target));
	end

	a_inst: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> issue_entry.entry.inst == exp_head.inst) else begin
		fail_cnt++;
		$error("Error at %0t: issue_entry.entry.inst %h, expected %h", $time,
			$sampled(issue_entry.entry.inst), $sampled(exp_head.inst));
	end

	a_tag: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> issue_entry.tag == exp_tag) else begin
		fail_cnt++;
		$error("Error at %0t: issue_entry.tag %0d, expected %0d", $time,
			$sampled(issue_entry.tag), $sampled(exp_tag));
	end

	a_route: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> issue_to_slb == is_mem) else begin
		fail_cnt++;
		$error("Error at %0t: issue_to_slb %b, expected %b", $time,
			$sampled(issue_to_slb), $sampled(is_mem));
	end

	a_stall: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> !rob_full && !(is_mem ? slb_full : rs_full)) else begin
		fail_cnt++;
		$error("issue at %0t while rob or target buffer was full", $time);
	end

endmodule

bind ifu_top ifu_checker u_chk (.*);

//--- verif/ifu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// runs ifu_top against a program memory, bht and random stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ifu_tb import fetch_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	logic         clk, rst, flush, mem_ack, bht_taken, rob_full, slb_full, rs_full;
	logic         mem_req, issue_valid, issue_to_slb;
	xlen_t        flush_pc, mem_addr, mem_data;
	bht_idx_t     bht_idx;
	issue_entry_t issue_entry;

	xlen_t       prog [64]; // indexed by addr[7:2] so higher addresses wrap
	logic [15:0] bht;
	logic [1:0]  ack_dly;   // cycles left before ack
	logic        stall_en;
	logic        hold_rob;  // rob kept full so the queue fills
	int          issued, timeouts;

	ifu_top UUT (.*);

	assign bht_taken = bht[bht_idx]; // answered within the ack cycle

	function automatic xlen_t enc_jal(int off);
		logic [20:0] im;
		im = 21'(off);
		enc_jal = {im[20], im[10:1], im[11], im[19:12], 5'd1, 7'h6f};
	endfunction

	function automatic xlen_t enc_branch(int off);
		logic [12:0] im;
		im = 13'(off);
		enc_branch = {im[12], im[10:5], 5'd2, 5'd1, 3'b001, im[4:1], im[11], 7'h63};
	endfunction

	initial begin
		for (int i = 0; i < 64; i++)
			case (i % 7)
				0: prog[i] = {12'(i), 5'd1, 3'b000, 5'(i), 7'h13};     // addi
				1: prog[i] = {12'd8, 5'd2, 3'b010, 5'd3, 7'h03};       // lw
				2: prog[i] = {7'd0, 5'd4, 5'd2, 3'b010, 5'd8, 7'h23};  // sw
				3: prog[i] = enc_branch((i % 2) ? 8 : -12);            // fwd or loop
				4: prog[i] = enc_jal(16);
				5: prog[i] = {12'd0, 5'd1, 3'b000, 5'd0, 7'h67};       // jalr
				default: prog[i] = {20'(i), 5'd5, 7'h37};              // lui
			endcase
		prog[63] = enc_jal(-252); // back to word 0
	end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// memory side of the four-phase handshake
	always @(posedge clk) begin
		if (rst) begin
			mem_ack <= 1'b0;
			ack_dly <= 2'd1;
		end else if (mem_ack) begin
			if (!mem_req) begin
				mem_ack <= 1'b0; // release after req drop
				ack_dly <= 2'($urandom_range(3));
			end
		end else if (mem_req) begin
			if (ack_dly == 2'd0) begin
				mem_ack  <= 1'b1;
				mem_data <= prog[mem_addr[7:2]];
			end else
				ack_dly <= ack_dly - 2'd1;
		end
	end

	always @(posedge clk) begin
		bht[$urandom_range(15)] <= 1'($urandom); // history drifts
		rob_full <= hold_rob || (stall_en && ($urandom_range(3) == 0));
		slb_full <= stall_en && ($urandom_range(3) == 0);
		rs_full  <= stall_en && ($urandom_range(3) == 0);
		if (!rst && issue_valid)
			issued <= issued + 1;
	end

	// bounded wait for n more issues
	task automatic wait_issues(input int n, input int limit);
		int goal;
		int cycles;
		goal = issued + n;
		cycles = 0;
		while (issued < goal && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (issued < goal) begin
			timeouts++;
			$display("timeout at %0t: only %0d of %0d issues seen", $time, issued, goal);
		end
	endtask

	// flush while a request still waits a cycle or more for ack
	task automatic flush_mid_fetch(input xlen_t pc);
		int cycles;
		cycles = 0;
		while (!(mem_req && !mem_ack && ack_dly != 2'd0) && cycles < 200) begin
			@(posedge clk);
			cycles++;
		end
		if (cycles >= 200) begin
			timeouts++;
			$display("timeout at %0t: no pending fetch to flush", $time);
		end
		flush    <= 1'b1;
		flush_pc <= pc;
		@(posedge clk);
		flush <= 1'b0;
	endtask

	initial begin
		void'($urandom(32'hb256));
		rst       = 1'b1;
		flush     = 1'b0;
		flush_pc  = '0;
		mem_ack   = 1'b0;
		mem_data  = '0;
		rob_full  = 1'b0;
		slb_full  = 1'b0;
		rs_full   = 1'b0;
		bht       = 16'($urandom);
		stall_en  = 1'b0;
		hold_rob  = 1'b0;
		issued    = 0;
		timeouts  = 0;
		repeat (4) @(posedge clk);
		rst      <= 1'b0;
		stall_en <= 1'b1;
		wait_issues(60, 3000);
		hold_rob <= 1'b1; // queue fills and fetch has to stop
		repeat (100) @(posedge clk);
		hold_rob <= 1'b0;
		flush_mid_fetch(32'h40);
		wait_issues(60, 3000);
		stall_en <= 1'b0; // drain without back-pressure
		wait_issues(20, 500);
		@(posedge clk);
		$display("issued %0d, timeouts %0d, assertion failures %0d", issued, timeouts,
			UUT.u_chk.fail_cnt);
		if (timeouts == 0 && UUT.u_chk.fail_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
